//--- verilog/floo_red_pkg.sv
// fixed to a 4x4 mesh with five routes; flit layout and status code are shared by all modules
package floo_red_pkg;

  // mesh dimensions
  localparam int unsigned MeshX = 4;
  localparam int unsigned MeshY = 4;
  // one group bit per node
  localparam int unsigned GroupW = MeshX * MeshY;

  // lowest route index wins arbitration
  localparam int unsigned NumRoutes  = 5;
  localparam int unsigned RouteLocal = 0;
  // north has the larger y
  localparam int unsigned RouteNorth = 1;
  // east has the larger x
  localparam int unsigned RouteEast  = 2;
  localparam int unsigned RouteSouth = 3;
  localparam int unsigned RouteWest  = 4;

  // node coordinate
  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } id_t;

  // flit kind
  typedef enum logic [1:0] {
    Unicast  = 2'd0,
    CollectB = 2'd1
  } commtype_e;

  // group_mask bit index is y * MeshX + x
  typedef struct packed {
    commtype_e         commtype;
    id_t               dst_id;
    logic [GroupW-1:0] group_mask;
  } hdr_t;

  // payload and its status field
  localparam int unsigned PayloadW = 32;
  localparam int unsigned StatusHi = 31;
  localparam int unsigned StatusLo = 30;
  localparam logic [1:0]  StatusError = 2'b10;

  typedef struct packed {
    hdr_t                hdr;
    logic [PayloadW-1:0] payload;
  } flit_t;

  typedef logic [NumRoutes-1:0] route_mask_t;
  typedef logic [2:0]           route_idx_t;

endpackage

//--- verilog/floo_first_one.sv
// lowest set bit wins; idx_o reads zero when the request is empty, so check empty_o first
`timescale 1ns/1ps

module floo_first_one #(
  parameter int unsigned Width = 5
) (
  input  logic [Width-1:0]                             req_i,
  output logic [((Width > 1) ? $clog2(Width) : 1)-1:0] idx_o,
  output logic                                         empty_o
);

  // a single-bit request still gets a one-bit index
  localparam int unsigned IdxW = (Width > 1) ? $clog2(Width) : 1;

  // scan from the top down
  // so the last hit is the lowest set bit
  always_comb begin : proc_scan
    idx_o = '0;
    for (int i = Width - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        idx_o = IdxW'(i);
      end
    end
  end

  // no request at all
  assign empty_o = ~|req_i;

endmodule

//--- verilog/floo_reduction_sync.sv
// mesh reduction-tree rule only; header match checks dst_id and group_mask, never commtype
`timescale 1ns/1ps

module floo_reduction_sync (
  input  floo_red_pkg::route_mask_t                          valid_i,
  input  floo_red_pkg::flit_t [floo_red_pkg::NumRoutes-1:0]  data_i,
  input  floo_red_pkg::id_t                                  node_id_i,
  input  floo_red_pkg::route_idx_t                           sel_idx_i,
  output floo_red_pkg::route_mask_t                          expected_mask_o,
  output logic                                               complete_o
);

  import floo_red_pkg::*;

  hdr_t        sel_hdr;
  route_mask_t expected_mask;
  // group members seen relative to this node
  logic        self_member;
  logic        west_member;
  logic        east_member;
  logic        south_member;
  logic        north_member;

  // header of the leading flit
  assign sel_hdr = data_i[sel_idx_i].hdr;

  // walk the group and classify each member against our coordinate
  always_comb begin : proc_member_scan
    self_member  = 1'b0;
    west_member  = 1'b0;
    east_member  = 1'b0;
    south_member = 1'b0;
    north_member = 1'b0;
    for (int gy = 0; gy < MeshY; gy++) begin
      for (int gx = 0; gx < MeshX; gx++) begin
        if (sel_hdr.group_mask[gy*MeshX+gx]) begin
          // same row feeds the east-west subtree
          if (gy == node_id_i.y) begin
            if (gx < node_id_i.x) west_member = 1'b1;
            if (gx > node_id_i.x) east_member = 1'b1;
            if (gx == node_id_i.x) self_member = 1'b1;
          end
          // any column counts for the vertical trunk
          if (gy < node_id_i.y) south_member = 1'b1;
          if (gy > node_id_i.y) north_member = 1'b1;
        end
      end
    end
  end

  // x first, then y toward the destination
  always_comb begin : proc_expected_mask
    expected_mask = '0;
    if (sel_hdr.commtype == CollectB) begin
      expected_mask[RouteLocal] = self_member;
      expected_mask[RouteWest]  = (node_id_i.x <= sel_hdr.dst_id.x) && west_member;
      expected_mask[RouteEast]  = (node_id_i.x >= sel_hdr.dst_id.x) && east_member;
      // vertical inputs only on the destination column
      expected_mask[RouteSouth] = (node_id_i.x == sel_hdr.dst_id.x) &&
                                  (node_id_i.y <= sel_hdr.dst_id.y) && south_member;
      expected_mask[RouteNorth] = (node_id_i.x == sel_hdr.dst_id.x) &&
                                  (node_id_i.y >= sel_hdr.dst_id.y) && north_member;
    end else begin
      // unicast travels alone
      expected_mask[sel_idx_i] = 1'b1;
    end
  end

  // leading route must be valid to cover the idle case
  // every expected route valid and part of the same collective
  always_comb begin : proc_complete
    complete_o = valid_i[sel_idx_i];
    for (int r = 0; r < NumRoutes; r++) begin
      if (expected_mask[r]) begin
        if (!valid_i[r]) complete_o = 1'b0;
        if (data_i[r].hdr.dst_id != sel_hdr.dst_id) complete_o = 1'b0;
        if (data_i[r].hdr.group_mask != sel_hdr.group_mask) complete_o = 1'b0;
      end
    end
  end

  assign expected_mask_o = expected_mask;

endmodule

//--- verilog/floo_reduction_arbiter.sv
// purely combinational; all expected routes are consumed in the same cycle as the output transfer
`timescale 1ns/1ps

// no state here, so clock and reset are left off the port list
module floo_reduction_arbiter (
  // input routes
  input  floo_red_pkg::route_mask_t                          valid_i,
  output floo_red_pkg::route_mask_t                          ready_o,
  input  floo_red_pkg::flit_t [floo_red_pkg::NumRoutes-1:0]  data_i,
  input  floo_red_pkg::id_t                                  node_id_i,
  // merged output
  output logic                                               valid_o,
  input  logic                                               ready_i,
  output floo_red_pkg::flit_t                                data_o
);

  import floo_red_pkg::*;

  route_idx_t  sel_idx;
  logic        none_valid;
  route_mask_t expected_mask;
  logic        complete;

  // lowest valid route leads
  floo_first_one #(
    .Width ( NumRoutes )
  ) first_one_inst (
    .req_i   ( valid_i    ),
    .idx_o   ( sel_idx    ),
    .empty_o ( none_valid )
  );

  floo_reduction_sync reduction_sync_inst (
    .valid_i         ( valid_i       ),
    .data_i          ( data_i        ),
    .node_id_i       ( node_id_i     ),
    .sel_idx_i       ( sel_idx       ),
    .expected_mask_o ( expected_mask ),
    .complete_o      ( complete      )
  );

  // first erroneous expected input wins, else the highest-indexed one
  always_comb begin : proc_merge
    flit_t last_flit;
    logic  error_found;
    last_flit   = data_i[sel_idx];
    error_found = 1'b0;
    data_o      = data_i[sel_idx];
    if (none_valid) begin
      // quiet bus while idle
      data_o = '0;
    end else if (data_i[sel_idx].hdr.commtype == CollectB) begin
      for (int r = 0; r < NumRoutes; r++) begin
        if (expected_mask[r] && !error_found) begin
          if (data_i[r].payload[StatusHi:StatusLo] == StatusError) begin
            data_o      = data_i[r];
            error_found = 1'b1;
          end else begin
            last_flit = data_i[r];
          end
        end
      end
      if (!error_found) begin
        data_o = last_flit;
      end
    end
  end

  assign valid_o = complete;

  // pop every contributor together, hold the rest
  assign ready_o = (complete && ready_i) ? expected_mask : '0;

endmodule

//--- verilog/floo_out_spill.sv
// one-entry register; accepts a new flit in the cycle the old one leaves, ready_o follows ready_i
`timescale 1ns/1ps

module floo_out_spill (
  input  logic                clk_i,
  input  logic                reset_i,
  // from the arbiter
  input  logic                valid_i,
  output logic                ready_o,
  input  floo_red_pkg::flit_t data_i,
  // toward the output link
  output logic                valid_o,
  input  logic                ready_i,
  output floo_red_pkg::flit_t data_o
);

  import floo_red_pkg::*;

  logic  full_q;
  flit_t data_q;
  logic  push;

  // take a flit when empty or when the held one drains now
  assign ready_o = ~full_q | ready_i;
  assign push    = valid_i & ready_o;

  // occupancy flag
  always_ff @(posedge clk_i) begin : proc_full
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      // output transfer with nothing behind it
      full_q <= 1'b0;
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin : proc_data
    if (push) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

//--- verilog/floo_reduction_port.sv
// one cycle from input transfer to valid_o; node_id_i is expected to stay stable during operation
`timescale 1ns/1ps

module floo_reduction_port (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  // input routes
  input  floo_red_pkg::route_mask_t                          valid_i,
  output floo_red_pkg::route_mask_t                          ready_o,
  input  floo_red_pkg::flit_t [floo_red_pkg::NumRoutes-1:0]  data_i,
  input  floo_red_pkg::id_t                                  node_id_i,
  // registered output
  output logic                                               valid_o,
  input  logic                                               ready_i,
  output floo_red_pkg::flit_t                                data_o
);

  import floo_red_pkg::*;

  // arbiter to output register
  logic  red_valid;
  logic  red_ready;
  flit_t red_data;

  floo_reduction_arbiter reduction_arbiter_inst (
    .valid_i   ( valid_i   ),
    .ready_o   ( ready_o   ),
    .data_i    ( data_i    ),
    .node_id_i ( node_id_i ),
    .valid_o   ( red_valid ),
    .ready_i   ( red_ready ),
    .data_o    ( red_data  )
  );

  // cuts the data path toward the link
  floo_out_spill out_spill_inst (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .valid_i ( red_valid ),
    .ready_o ( red_ready ),
    .data_i  ( red_data  ),
    .valid_o ( valid_o   ),
    .ready_i ( ready_i   ),
    .data_o  ( data_o    )
  );

endmodule

//--- verif/tb_floo_reduction_port.sv
// router fixed at node (1,1); inputs change on the falling edge, outputs are read 1 ns later
`timescale 1ns/1ps

module tb_floo_reduction_port;

  import floo_red_pkg::*;

  localparam int                Timeout = 50;
  localparam logic [GroupW-1:0] Group   = 16'h0072;
  localparam id_t               Dst     = '{x: 2'd1, y: 2'd3};

  logic                  clk_i;
  logic                  reset_i;
  route_mask_t           valid_i;
  route_mask_t           ready_o;
  flit_t [NumRoutes-1:0] data_i;
  id_t                   node_id_i;
  logic                  valid_o;
  logic                  ready_i;
  flit_t                 data_o;
  int                    errors;
  int                    seed;

  floo_reduction_port floo_reduction_port_inst (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .valid_i   ( valid_i   ),
    .ready_o   ( ready_o   ),
    .data_i    ( data_i    ),
    .node_id_i ( node_id_i ),
    .valid_o   ( valid_o   ),
    .ready_i   ( ready_i   ),
    .data_o    ( data_o    )
  );

  initial begin : proc_clk
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input route_mask_t got, input route_mask_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // random payload with forced status bits
  function automatic flit_t new_flit(input commtype_e ct, input id_t dst,
                                     input logic [GroupW-1:0] grp, input logic [1:0] status);
    flit_t f;
    f.hdr.commtype   = ct;
    f.hdr.dst_id     = dst;
    f.hdr.group_mask = grp;
    f.payload        = $random(seed);
    f.payload[StatusHi:StatusLo] = status;
    return f;
  endfunction

  function automatic int ref_lowest(input route_mask_t v);
    int idx;
    idx = -1;
    for (int r = 0; r < NumRoutes; r++) begin
      if (v[r] && idx < 0) idx = r;
    end
    return idx;
  endfunction

  // reduction tree runs x toward the destination column, then y along it
  function automatic route_mask_t ref_mask(input id_t node, input flit_t lead, input int lead_r);
    route_mask_t m;
    int          mx;
    int          my;
    int          nx;
    int          ny;
    m  = '0;
    nx = int'(node.x);
    ny = int'(node.y);
    if (lead.hdr.commtype != CollectB) begin
      m[lead_r] = 1'b1;
      return m;
    end
    for (int i = 0; i < GroupW; i++) begin
      mx = i % MeshX;
      my = i / MeshX;
      if (lead.hdr.group_mask[i]) begin
        if (mx == nx && my == ny) m[RouteLocal] = 1'b1;
        if (my == ny && mx < nx && nx <= int'(lead.hdr.dst_id.x)) m[RouteWest] = 1'b1;
        if (my == ny && mx > nx && nx >= int'(lead.hdr.dst_id.x)) m[RouteEast] = 1'b1;
        if (nx == int'(lead.hdr.dst_id.x)) begin
          if (my < ny && ny <= int'(lead.hdr.dst_id.y)) m[RouteSouth] = 1'b1;
          if (my > ny && ny >= int'(lead.hdr.dst_id.y)) m[RouteNorth] = 1'b1;
        end
      end
    end
    return m;
  endfunction

  // first erroneous contributor, otherwise the highest-indexed one
  function automatic flit_t ref_merge(input flit_t [NumRoutes-1:0] d, input route_mask_t m);
    flit_t res;
    logic  err;
    res = '0;
    err = 1'b0;
    for (int r = 0; r < NumRoutes; r++) begin
      if (m[r] && !err) res = d[r];
      if (m[r] && !err && d[r].payload[StatusHi:StatusLo] == StatusError) err = 1'b1;
    end
    return res;
  endfunction

  task automatic apply_reset();
    reset_i = 1'b1;
    valid_i = '0;
    ready_i = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
  endtask

  // called right after driving at a falling edge
  task automatic consume_check(input route_mask_t exp_ready, input flit_t exp_flit);
    route_mask_t got;
    int          n;
    got = '0;
    n   = 0;
    while (got == '0 && n < Timeout) begin
      #1;
      got = ready_o;
      if (got == '0) begin
        @(negedge clk_i);
        n++;
      end
    end
    if (got == '0) begin
      $display("timeout: no input route was accepted within %0d cycles", Timeout);
      errors++;
    end else begin
      check_mask("ready_o", got, exp_ready);
      // merged flit one cycle after the input transfer
      @(negedge clk_i);
      valid_i = valid_i & ~got;
      #1;
      check_bit("valid_o", valid_o, 1'b1);
      check_flit("data_o", data_o, exp_flit);
    end
  endtask

  task automatic expect_reduction();
    int          lead;
    route_mask_t m;
    lead = ref_lowest(valid_i);
    m    = ref_mask(node_id_i, data_i[lead], lead);
    consume_check(m, ref_merge(data_i, m));
  endtask

  task automatic check_idle();
    @(negedge clk_i);
    #1;
    check_bit("valid_o", valid_o, 1'b0);
    check_mask("ready_o", ready_o, '0);
  endtask

  task automatic expect_stall(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      #1;
      check_mask("ready_o", ready_o, '0);
      check_bit("valid_o", valid_o, 1'b0);
      @(negedge clk_i);
    end
  endtask

  // same collective on local, east, south and west
  task automatic load_collective(input logic [1:0] east_status, input logic [GroupW-1:0] west_grp);
    data_i             = '0;
    data_i[RouteLocal] = new_flit(CollectB, Dst, Group, 2'b00);
    data_i[RouteEast]  = new_flit(CollectB, Dst, Group, east_status);
    data_i[RouteSouth] = new_flit(CollectB, Dst, Group, 2'b01);
    data_i[RouteWest]  = new_flit(CollectB, Dst, west_grp, 2'b00);
  endtask

  task automatic unicast_test();
    #1;
    check_bit("valid_o", valid_o, 1'b0);
    check_mask("ready_o", ready_o, '0);
    @(negedge clk_i);
    data_i[RouteEast]  = new_flit(Unicast, Dst, Group, 2'b01);
    valid_i[RouteEast] = 1'b1;
    expect_reduction();
    check_idle();
  endtask

  task automatic collective_test(input logic [1:0] east_status);
    @(negedge clk_i);
    load_collective(east_status, Group);
    valid_i = route_mask_t'(5'b11101);
    expect_reduction();
    check_idle();
  endtask

  task automatic partial_arrival_test();
    @(negedge clk_i);
    load_collective(2'b00, Group);
    valid_i = route_mask_t'(5'b00101);
    expect_stall(3);
    valid_i[RouteSouth] = 1'b1;
    expect_stall(3);
    valid_i[RouteWest] = 1'b1;
    expect_reduction();
    check_idle();
    // west belongs to another collective so nothing may leave
    @(negedge clk_i);
    load_collective(2'b00, Group | 16'h8000);
    valid_i = route_mask_t'(5'b11101);
    expect_stall(5);
    apply_reset();
  endtask

  task automatic backpressure_test();
    flit_t first;
    @(negedge clk_i);
    ready_i = 1'b0;
    first   = new_flit(Unicast, Dst, Group, 2'b00);
    data_i[RouteLocal]  = first;
    valid_i[RouteLocal] = 1'b1;
    consume_check(route_mask_t'(5'b00001), first);
    // collective waits behind the full register
    @(negedge clk_i);
    load_collective(2'b00, Group);
    valid_i = route_mask_t'(5'b11101);
    for (int i = 0; i < 4; i++) begin
      #1;
      check_bit("valid_o", valid_o, 1'b1);
      check_flit("data_o", data_o, first);
      check_mask("ready_o", ready_o, '0);
      @(negedge clk_i);
    end
    ready_i = 1'b1;
    expect_reduction();
    check_idle();
  endtask

  // model tracks the output register as a queue of expected flits
  task automatic random_unicast_test();
    flit_t       exp_q[$];
    route_mask_t consumed;
    route_mask_t exp_ready;
    logic [31:0] rnd;
    logic        full;
    int          launched;
    int          cycles;
    consumed = '0;
    launched = 0;
    cycles   = 0;
    while ((launched < 20 || valid_i != '0 || exp_q.size() != 0) && cycles < 20 * Timeout) begin
      @(negedge clk_i);
      valid_i = valid_i & ~consumed;
      for (int r = 0; r < NumRoutes; r++) begin
        rnd = $random(seed);
        if (!valid_i[r] && launched < 20 && rnd[31]) begin
          data_i[r]  = new_flit(Unicast, rnd[3:0], rnd[19:4], rnd[21:20]);
          valid_i[r] = 1'b1;
          launched++;
        end
      end
      rnd     = $random(seed);
      ready_i = rnd[0];
      #1;
      full = (exp_q.size() != 0);
      check_bit("valid_o", valid_o, full);
      if (full && ready_i) check_flit("data_o", data_o, exp_q.pop_front());
      exp_ready = '0;
      if (valid_i != '0 && (!full || ready_i)) exp_ready[ref_lowest(valid_i)] = 1'b1;
      check_mask("ready_o", ready_o, exp_ready);
      consumed = exp_ready;
      if (exp_ready != '0) exp_q.push_back(data_i[ref_lowest(valid_i)]);
      cycles++;
    end
    if (cycles >= 20 * Timeout) begin
      $display("timeout: random unicast traffic did not drain");
      errors++;
    end
    @(negedge clk_i);
    valid_i = '0;
    ready_i = 1'b1;
  endtask

  initial begin : proc_main
    seed      = 48642;
    errors    = 0;
    reset_i   = 1'b1;
    valid_i   = '0;
    data_i    = '0;
    ready_i   = 1'b1;
    node_id_i = '{x: 2'd1, y: 2'd1};
    apply_reset();
    unicast_test();
    collective_test(2'b00);
    collective_test(StatusError);
    partial_arrival_test();
    backpressure_test();
    random_unicast_test();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/floo_red_pkg.sv
verilog/floo_first_one.sv
verilog/floo_reduction_sync.sv
verilog/floo_reduction_arbiter.sv
verilog/floo_out_spill.sv
verilog/floo_reduction_port.sv
verif/tb_floo_reduction_port.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it into sim.log and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
  --top-module tb_floo_reduction_port -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
